/* dv/coproc_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module coproc_checker (
   input logic        clkrst_core_clk,
   input logic        clkrst_core_rst_n,
   input logic        exception,
   input logic        coproc_instruction,
   input logic [8:0]  opcode,
   input logic        branch,
   input logic [27:0] branch_addr,
   input logic        user_mode,
   input logic [27:0] eha_target
);

   import coproc_pkg::*;

   int   fail_count = 0;
   logic eret_qual;

   assign eret_qual = coproc_instruction && (opcode[8:5] == coproc_op_eret);

   // Redirect only for an exception or a real return
   a_branch_source: assert property (
      @(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
      branch == (exception || eret_qual)
   ) else begin
      fail_count++;
      $error("branch does not follow exception or return");
   end

   a_user_cleared: assert property (
      @(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
      exception |=> !user_mode
   ) else begin
      fail_count++;
      $error("user_mode still set in the cycle after an exception");
   end

   // Handler entry point on exception
   a_eha_target: assert property (
      @(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
      exception |-> branch_addr == eha_target
   ) else begin
      fail_count++;
      $error("branch_addr differs from the EHA target on exception");
   end

endmodule

`default_nettype wire

/* dv/coproc_tb.sv */
`timescale 1ns/1ns
`default_nettype none

bind coproc_top coproc_checker u_coproc_checker (
   .clkrst_core_clk    (clkrst_core_clk),
   .clkrst_core_rst_n  (clkrst_core_rst_n),
   .exception          (exception),
   .coproc_instruction (coproc_instruction),
   .opcode             (opcode),
   .branch             (branch),
   .branch_addr        (branch_addr),
   .user_mode          (user_mode),
   .eha_target         (status.eha_target)
);

module coproc_tb;

   import coproc_pkg::*;

   localparam int num_random = 2000;
   localparam int watchdog_ns = (3 + 32 + num_random + 100) * 10;

   logic            clkrst_core_clk;
   logic            clkrst_core_rst_n;
   logic [31:0]     rs_data;
   coproc_reg_num_u rs_num;
   coproc_reg_num_u rd_num;
   logic [8:0]      opcode;
   logic            coproc_instruction;
   logic            exception;
   coproc_fault_s   fault;
   logic [31:0]     reg_result;
   logic            rd_we;
   logic            user_mode;
   logic            paging_on;
   logic            interrupts_enabled;
   logic            branch;
   logic [27:0]     branch_addr;

   // Shadow copy of the coprocessor state
   logic [31:0] m_ctrl    [coproc_num_ctrl];
   logic [31:0] m_scratch [coproc_num_scratch];
   logic        m_user;

   int seed = 74884;
   int n_exception = 0;
   int n_eret = 0;
   int n_write = 0;

   coproc_top u_coproc_top (
      .clkrst_core_clk    (clkrst_core_clk),
      .clkrst_core_rst_n  (clkrst_core_rst_n),
      .rs_data            (rs_data),
      .rs_num             (rs_num),
      .rd_num             (rd_num),
      .opcode             (opcode),
      .coproc_instruction (coproc_instruction),
      .exception          (exception),
      .fault              (fault),
      .reg_result         (reg_result),
      .rd_we              (rd_we),
      .user_mode          (user_mode),
      .paging_on          (paging_on),
      .interrupts_enabled (interrupts_enabled),
      .branch             (branch),
      .branch_addr        (branch_addr)
   );

   initial begin
      clkrst_core_clk = 1'b0;
      forever #5 clkrst_core_clk = ~clkrst_core_clk;
   end

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped on the first error");
   endtask

   task automatic check_word(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
      if (actual !== expected) begin
         stop_on_error($sformatf("FAILED at %0t ns: %s is %h, expected %h",
                                 $time, what, actual, expected));
      end
   endtask

   task automatic check_flag(input string what, input logic actual, input logic expected);
      if (actual !== expected) begin
         stop_on_error($sformatf("FAILED at %0t ns: %s is %b, expected %b",
                                 $time, what, actual, expected));
      end
   endtask

   task automatic check_status(input coproc_status_s actual, input coproc_status_s expected);
      if (actual !== expected) begin
         stop_on_error($sformatf("FAILED at %0t ns: status is %h, expected %h",
                                 $time, actual, expected));
      end
   endtask

   task automatic check_redirect(input logic actual_br, input logic [27:0] actual_addr,
                                 input logic expected_br, input logic [27:0] expected_addr);
      if (actual_br !== expected_br || actual_addr !== expected_addr) begin
         stop_on_error($sformatf("FAILED at %0t ns: redirect %b/%h, expected %b/%h",
                                 $time, actual_br, actual_addr, expected_br, expected_addr));
      end
   endtask

   function automatic logic [31:0] model_read(input coproc_reg_num_u num);
      if (num.scratch.sel) begin
         return m_scratch[num.scratch.idx];
      end
      if (num.ctrl.idx < 4'd10) begin
         return m_ctrl[num.ctrl.idx];
      end
      return 32'd0;
   endfunction

   function automatic coproc_status_s model_status();
      coproc_status_s s;
      s.paging_on  = m_ctrl[coproc_reg_ctrl][1];
      s.int_en     = m_ctrl[coproc_reg_ctrl][0];
      s.eha_target = m_ctrl[coproc_reg_eha][31:4];
      s.epc_target = m_ctrl[coproc_reg_epc][31:4];
      s.saved_ie   = m_ctrl[coproc_reg_epc][1];
      s.saved_user = m_ctrl[coproc_reg_epc][0];
      return s;
   endfunction

   // Exception over return over move-to
   task automatic model_step(input logic eret_q, input logic mtc_q);
      if (exception) begin
         m_ctrl[coproc_reg_epc] = {fault.virt_pc, 2'b00, m_ctrl[coproc_reg_ctrl][0], m_user};
         m_ctrl[coproc_reg_cause] = {23'd0, fault.int_type, fault.ec[0]};
         m_ctrl[5] = {27'd0, fault.ec[1]};
         m_ctrl[6] = {27'd0, fault.ec[2]};
         m_ctrl[7] = {27'd0, fault.ec[3]};
         m_ctrl[8] = fault.vaddr[0];
         m_ctrl[9] = fault.vaddr[1];
         m_user = 1'b0;
      end else if (eret_q) begin
         m_ctrl[coproc_reg_ctrl][0] = m_ctrl[coproc_reg_epc][1];
         m_user = m_ctrl[coproc_reg_epc][0];
      end else if (mtc_q) begin
         if (rd_num.scratch.sel) begin
            m_scratch[rd_num.scratch.idx] = rs_data;
         end else if (rd_num.ctrl.idx < 4'd10) begin
            m_ctrl[rd_num.ctrl.idx] = rs_data;
         end
      end
   endtask

   task automatic drive_idle(input logic [4:0] num);
      rs_data            = 32'd0;
      rs_num             = num;
      rd_num             = 5'd0;
      opcode             = 9'd0;
      coproc_instruction = 1'b0;
      exception          = 1'b0;
      fault              = '0;
   endtask

   task automatic drive_random();
      logic [31:0] r;
      logic [31:0] pick;
      logic [3:0]  op;
      r = $random(seed);
      pick = r % 32'd100;
      // About 10 percent returns, the rest mostly moves
      if (pick < 32'd10) begin
         op = coproc_op_eret;
      end else if (pick < 32'd55) begin
         op = coproc_op_mtc;
      end else if (pick < 32'd95) begin
         op = coproc_op_mfc;
      end else begin
         op = r[11:8];
      end
      r = $random(seed);
      opcode = {op, r[4:0]};
      rs_num = r[9:5];
      rd_num = r[14:10];
      coproc_instruction = (r[31:28] != 4'd0);
      rs_data = $random(seed);
      r = $random(seed);
      exception = (r % 32'd100) < 32'd5;
      r = $random(seed);
      fault.virt_pc  = r[27:0];
      fault.int_type = r[31:28];
      r = $random(seed);
      fault.ec[0] = r[4:0];
      fault.ec[1] = r[9:5];
      fault.ec[2] = r[14:10];
      fault.ec[3] = r[19:15];
      fault.vaddr[0] = $random(seed);
      fault.vaddr[1] = $random(seed);
   endtask

   // Samples mid cycle, then advances the model
   task automatic check_cycle();
      logic           eret_q;
      logic           mtc_q;
      logic           mfc_q;
      logic [27:0]    exp_addr;
      coproc_status_s exp_status;
      #4;
      eret_q = coproc_instruction && (opcode[8:5] == coproc_op_eret);
      mtc_q  = coproc_instruction && (opcode[8:5] == coproc_op_mtc);
      mfc_q  = coproc_instruction && (opcode[8:5] == coproc_op_mfc);
      exp_status = model_status();
      exp_addr = exception ? exp_status.eha_target : exp_status.epc_target;
      check_word("reg_result", reg_result, model_read(rs_num));
      check_flag("rd_we", rd_we, mfc_q);
      check_flag("user_mode", user_mode, m_user);
      check_flag("paging_on", paging_on, exp_status.paging_on);
      check_flag("interrupts_enabled", interrupts_enabled, exp_status.int_en);
      check_status(u_coproc_top.status, exp_status);
      check_redirect(branch, branch_addr, exception || eret_q, exp_addr);
      if (u_coproc_top.u_coproc_checker.fail_count != 0) begin
         stop_on_error("A concurrent assertion in the bound checker failed");
      end
      if (exception) begin
         n_exception++;
      end else if (eret_q) begin
         n_eret++;
      end else if (mtc_q) begin
         n_write++;
      end
      model_step(eret_q, mtc_q);
   endtask

   initial begin
      #(watchdog_ns);
      stop_on_error("Timeout: the test did not finish in the expected time");
   end

   initial begin
      clkrst_core_rst_n = 1'b0;
      drive_idle(5'd0);
      for (int i = 0; i < coproc_num_ctrl; i++) begin
         m_ctrl[i] = 32'd0;
      end
      for (int i = 0; i < coproc_num_scratch; i++) begin
         m_scratch[i] = 32'd0;
      end
      m_user = 1'b0;
      repeat (3) @(posedge clkrst_core_clk);
      #1 clkrst_core_rst_n = 1'b1;
      // Every register number reads zero after reset
      for (int i = 0; i < 32; i++) begin
         @(posedge clkrst_core_clk);
         #1;
         drive_idle(i[4:0]);
         check_cycle();
      end
      repeat (num_random) begin
         @(posedge clkrst_core_clk);
         #1;
         drive_random();
         check_cycle();
      end
      // Idle cycle so the checker samples the last random cycle
      @(posedge clkrst_core_clk);
      #1;
      drive_idle(5'd0);
      check_cycle();
      if (n_exception > 0 && n_eret > 0 && n_write > 0) begin
         $display("SIMULATION PASSED");
         $finish;
      end else begin
         $display("Random stimulus missed exceptions, returns or writes");
         $display("SIMULATION FAILED");
         $fatal(1, "incomplete stimulus");
      end
   end

endmodule

`default_nettype wire

/* hw/coproc_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module coproc_decode (
   input  logic [8:0]                  opcode,
   input  logic                        coproc_instruction,
   input  coproc_pkg::coproc_reg_num_u rs_num,
   input  coproc_pkg::coproc_reg_num_u rd_num,
   input  logic [31:0]                 rs_data,
   output coproc_pkg::coproc_wr_s      wr,
   output coproc_pkg::coproc_reg_num_u rd_sel,
   output logic                        eret_req,
   output logic                        rd_we
);

   import coproc_pkg::*;

   logic [3:0] op_major;
   logic       is_eret;
   logic       is_mfc;
   logic       is_mtc;

   // Only the top four bits pick the coprocessor operation
   assign op_major = opcode[8:5];

   assign is_eret = (op_major == coproc_op_eret);
   assign is_mfc  = (op_major == coproc_op_mfc);
   assign is_mtc  = (op_major == coproc_op_mtc);

   assign eret_req = coproc_instruction & is_eret;
   assign rd_we    = coproc_instruction & is_mfc;

   // Move-to writes rs_data into the register named by rd
   always_comb begin
      wr.valid = coproc_instruction & is_mtc;
      wr.num   = rd_num;
      wr.data  = rs_data;
   end

   // Move-from reads the register named by rs
   assign rd_sel = rs_num;

endmodule

`default_nettype wire

/* hw/coproc_pkg.sv */
`default_nettype none

package coproc_pkg;

   // Register map
   localparam int coproc_num_ctrl    = 10;
   localparam int coproc_num_scratch = 4;

   localparam int coproc_reg_ctrl  = 0;
   localparam int coproc_reg_eha   = 2;
   localparam int coproc_reg_epc   = 3;
   localparam int coproc_reg_cause = 4;

   // Top four opcode bits of the coprocessor instructions
   localparam logic [3:0] coproc_op_eret = 4'b0100;
   localparam logic [3:0] coproc_op_mfc  = 4'b0110;
   localparam logic [3:0] coproc_op_mtc  = 4'b0111;

   typedef struct packed {
      logic       sel;
      logic [1:0] unused;
      logic [1:0] idx;
   } coproc_scratch_num_s;

   typedef struct packed {
      logic       sel;
      logic [3:0] idx;
   } coproc_ctrl_num_s;

   // Top bit set selects the scratchpad view
   typedef union packed {
      coproc_scratch_num_s scratch;
      coproc_ctrl_num_s    ctrl;
   } coproc_reg_num_u;

   typedef struct packed {
      logic [27:0]      virt_pc;
      logic [3:0]       int_type;
      logic [3:0][4:0]  ec;
      logic [1:0][31:0] vaddr;
   } coproc_fault_s;

   typedef struct packed {
      logic            valid;
      coproc_reg_num_u num;
      logic [31:0]     data;
   } coproc_wr_s;

   typedef struct packed {
      logic        paging_on;
      logic        int_en;
      logic [27:0] eha_target;
      logic [27:0] epc_target;
      logic        saved_ie;
      logic        saved_user;
   } coproc_status_s;

endpackage

`default_nettype wire

/* hw/coproc_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module coproc_regfile (
   input  logic                        clkrst_core_clk,
   input  logic                        clkrst_core_rst_n,
   input  coproc_pkg::coproc_wr_s      wr,
   input  coproc_pkg::coproc_reg_num_u rd_sel,
   input  logic                        capture,
   input  coproc_pkg::coproc_fault_s   fault,
   input  logic                        save_ie,
   input  logic                        save_user,
   input  logic                        restore,
   output logic [31:0]                 reg_result,
   output coproc_pkg::coproc_status_s  status
);

   import coproc_pkg::*;

   logic [31:0] ctrl_regs [coproc_num_ctrl];
   logic [31:0] scratch   [coproc_num_scratch];

   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         for (int i = 0; i < coproc_num_ctrl; i++) begin
            ctrl_regs[i] <= 32'd0;
         end
         for (int i = 0; i < coproc_num_scratch; i++) begin
            scratch[i] <= 32'd0;
         end
      end else if (capture) begin
         // Return PC with saved mode bits below it
         ctrl_regs[coproc_reg_epc] <= {fault.virt_pc, 2'b00, save_ie, save_user};
         ctrl_regs[coproc_reg_cause] <= {23'd0, fault.int_type, fault.ec[0]};
         for (int i = 1; i < 4; i++) begin
            ctrl_regs[coproc_reg_cause + i] <= {27'd0, fault.ec[i]};
         end
         // Faulting addresses follow the error codes
         for (int i = 0; i < 2; i++) begin
            ctrl_regs[coproc_reg_cause + 4 + i] <= fault.vaddr[i];
         end
      end else if (restore) begin
         ctrl_regs[coproc_reg_ctrl][0] <= ctrl_regs[coproc_reg_epc][1];
      end else if (wr.valid) begin
         if (wr.num.scratch.sel) begin
            scratch[wr.num.scratch.idx] <= wr.data;
         end else if (int'(wr.num.ctrl.idx) < coproc_num_ctrl) begin
            ctrl_regs[wr.num.ctrl.idx] <= wr.data;
         end
      end
   end

   always_comb begin
      if (rd_sel.scratch.sel) begin
         reg_result = scratch[rd_sel.scratch.idx];
      end else if (int'(rd_sel.ctrl.idx) < coproc_num_ctrl) begin
         reg_result = ctrl_regs[rd_sel.ctrl.idx];
      end else begin
         // Unmapped control index
         reg_result = 32'd0;
      end
   end

   always_comb begin
      status.paging_on  = ctrl_regs[coproc_reg_ctrl][1];
      status.int_en     = ctrl_regs[coproc_reg_ctrl][0];
      status.eha_target = ctrl_regs[coproc_reg_eha][31:4];
      status.epc_target = ctrl_regs[coproc_reg_epc][31:4];
      status.saved_ie   = ctrl_regs[coproc_reg_epc][1];
      status.saved_user = ctrl_regs[coproc_reg_epc][0];
   end

endmodule

`default_nettype wire

/* hw/coproc_top.sv */
`timescale 1ns/1ns
`default_nettype none

module coproc_top (
   input  logic                        clkrst_core_clk,
   input  logic                        clkrst_core_rst_n,
   input  logic [31:0]                 rs_data,
   input  coproc_pkg::coproc_reg_num_u rs_num,
   input  coproc_pkg::coproc_reg_num_u rd_num,
   input  logic [8:0]                  opcode,
   input  logic                        coproc_instruction,
   input  logic                        exception,
   input  coproc_pkg::coproc_fault_s   fault,
   output logic [31:0]                 reg_result,
   output logic                        rd_we,
   output logic                        user_mode,
   output logic                        paging_on,
   output logic                        interrupts_enabled,
   output logic                        branch,
   output logic [27:0]                 branch_addr
);

   import coproc_pkg::*;

   coproc_wr_s      wr;
   coproc_reg_num_u rd_sel;
   logic            eret_req;
   logic            capture;
   coproc_fault_s   capture_fault;
   logic            restore;
   logic            save_ie;
   logic            save_user;
   coproc_status_s  status;

   coproc_decode u_decode (
      .opcode             (opcode),
      .coproc_instruction (coproc_instruction),
      .rs_num             (rs_num),
      .rd_num             (rd_num),
      .rs_data            (rs_data),
      .wr                 (wr),
      .rd_sel             (rd_sel),
      .eret_req           (eret_req),
      .rd_we              (rd_we)
   );

   coproc_trap u_trap (
      .clkrst_core_clk   (clkrst_core_clk),
      .clkrst_core_rst_n (clkrst_core_rst_n),
      .exception         (exception),
      .eret_req          (eret_req),
      .fault             (fault),
      .status            (status),
      .capture           (capture),
      .capture_fault     (capture_fault),
      .restore           (restore),
      .save_ie           (save_ie),
      .save_user         (save_user),
      .user_mode         (user_mode),
      .branch            (branch),
      .branch_addr       (branch_addr)
   );

   coproc_regfile u_regfile (
      .clkrst_core_clk   (clkrst_core_clk),
      .clkrst_core_rst_n (clkrst_core_rst_n),
      .wr                (wr),
      .rd_sel            (rd_sel),
      .capture           (capture),
      .fault             (capture_fault),
      .save_ie           (save_ie),
      .save_user         (save_user),
      .restore           (restore),
      .reg_result        (reg_result),
      .status            (status)
   );

   assign paging_on          = status.paging_on;
   assign interrupts_enabled = status.int_en;

endmodule

`default_nettype wire

/* hw/coproc_trap.sv */
`timescale 1ns/1ns
`default_nettype none

module coproc_trap (
   input  logic                       clkrst_core_clk,
   input  logic                       clkrst_core_rst_n,
   input  logic                       exception,
   input  logic                       eret_req,
   input  coproc_pkg::coproc_fault_s  fault,
   input  coproc_pkg::coproc_status_s status,
   output logic                       capture,
   output coproc_pkg::coproc_fault_s  capture_fault,
   output logic                       restore,
   output logic                       save_ie,
   output logic                       save_user,
   output logic                       user_mode,
   output logic                       branch,
   output logic [27:0]                branch_addr
);

   import coproc_pkg::*;

   // Exception wins over a return in the same cycle
   assign capture = exception;
   assign restore = eret_req & ~exception;

   // Regfile latches this only on capture
   assign capture_fault = fault;

   // Mode bits as they stand before the trap
   assign save_ie   = status.int_en;
   assign save_user = user_mode;

   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         user_mode <= 1'b0;
      end else if (exception) begin
         user_mode <= 1'b0;
      end else if (eret_req) begin
         user_mode <= status.saved_user;
      end
   end

   assign branch = exception | eret_req;

   // Handler entry on exception, else back to the saved PC
   assign branch_addr = exception ? status.eha_target : status.epc_target;

endmodule

`default_nettype wire

/* list.f */
hw/coproc_pkg.sv
hw/coproc_decode.sv
hw/coproc_trap.sv
hw/coproc_regfile.sv
hw/coproc_top.sv
dv/coproc_checker.sv
dv/coproc_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the coprocessor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module coproc_tb \
   -f list.f -o coproc_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

# Let assertion errors reach the testbench so it can report them
./obj_dir/coproc_sim +verilator+error+limit+10 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
   echo "Run passed"
   exit 0
else
   echo "Run failed, see $LOG"
   exit 1
fi
